//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_request_front
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TB PASSED" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/fifo_queue.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_queue
#(
    parameter int  QUEUE_SIZE = 16,
    parameter type payload_t  = logic [31 : 0]
)
(
    input  wire         clk_in,
    input  wire         reset_in,

    output logic        is_empty,
    output logic        is_full,

    // Upstream side
    input  wire payload_t request_in,
    input  wire         request_valid_in,
    output logic        issue_ack_out,

    // Downstream side
    output payload_t    request_out,
    output logic        request_valid_out,
    input  wire         issue_ack_in
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointer sizing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int PTR_WIDTH = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1;

    localparam logic [PTR_WIDTH - 1 : 0] LAST_SLOT = PTR_WIDTH'(QUEUE_SIZE - 1);

    // Wrap at the last slot, depth need not be a power of two
    function automatic logic [PTR_WIDTH - 1 : 0] next_ptr
    (
        input logic [PTR_WIDTH - 1 : 0] ptr
    );
        if (ptr == LAST_SLOT)
        begin
            return '0;
        end
        else
        begin
            return ptr + 1'b1;
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage and pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    payload_t                   entries [QUEUE_SIZE];
    logic [QUEUE_SIZE - 1 : 0]  entry_valid;

    logic [PTR_WIDTH - 1 : 0]   write_ptr;
    logic [PTR_WIDTH - 1 : 0]   read_ptr;

    logic                       write_fire;
    logic                       read_fire;

    assign is_full  = &entry_valid;
    assign is_empty = ~|entry_valid;

    // Head leaves when the consumer acks a valid head entry
    assign read_fire = issue_ack_in & entry_valid[read_ptr];

    // When full, write_ptr equals read_ptr, so a head ack frees the very
    // slot being written and the accept does not have to wait a cycle
    assign write_fire = request_valid_in & ~issue_ack_out & (~is_full | read_fire);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            write_ptr     <= '0;
            issue_ack_out <= 1'b0;
        end
        else
        begin
            issue_ack_out <= write_fire;
            if (write_fire)
            begin
                write_ptr <= next_ptr(write_ptr);
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (write_fire)
        begin
            entries[write_ptr] <= request_in;
        end
    end

    // Set after clear, so a same-slot write and read leaves it valid
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            entry_valid <= '0;
        end
        else
        begin
            if (read_fire)
            begin
                entry_valid[read_ptr] <= 1'b0;
            end
            if (write_fire)
            begin
                entry_valid[write_ptr] <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Head valid drops for one cycle after each ack
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            read_ptr          <= '0;
            request_valid_out <= 1'b0;
        end
        else if (read_fire)
        begin
            read_ptr          <= next_ptr(read_ptr);
            request_valid_out <= 1'b0;
        end
        else
        begin
            request_valid_out <= entry_valid[read_ptr];
        end
    end

    // Only meaningful while request_valid_out is high
    always_ff @(posedge clk_in)
    begin
        request_out <= entries[read_ptr];
    end

endmodule

`default_nettype wire

//--- design/mem_req_defs.svh
`ifndef MEM_REQ_DEFS_SVH
`define MEM_REQ_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory request widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MEM_ADDR_WIDTH 32
// Byte mask width follows as MEM_DATA_WIDTH/8
`define MEM_DATA_WIDTH 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Queue depths in entries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define LOAD_QUEUE_SIZE 8
`define STORE_QUEUE_SIZE 4

`endif

//--- design/mem_req_pkg.sv
`default_nettype none

`include "mem_req_defs.svh"

package mem_req_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Queue payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Load queue entry
    typedef struct packed {
        logic [`MEM_ADDR_WIDTH - 1 : 0]         addr;
    } load_req_t;

    // Store queue entry
    typedef struct packed {
        logic [`MEM_ADDR_WIDTH - 1 : 0]         addr;
        logic [`MEM_DATA_WIDTH - 1 : 0]         data;
        logic [(`MEM_DATA_WIDTH / 8) - 1 : 0]   mask;
    } store_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Merged request towards memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Data and mask are zero for loads
    typedef struct packed {
        logic                                   is_store;
        logic [`MEM_ADDR_WIDTH - 1 : 0]         addr;
        logic [`MEM_DATA_WIDTH - 1 : 0]         data;
        logic [(`MEM_DATA_WIDTH / 8) - 1 : 0]   mask;
    } mem_req_t;

endpackage

`default_nettype wire

//--- design/mem_request_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_request_arbiter
    import mem_req_pkg::*;
(
    input  wire         clk_in,
    input  wire         reset_in,

    // Load queue head
    input  wire load_req_t load_head,
    input  wire         load_head_valid,
    output logic        load_head_ack,

    // Store queue head
    input  wire store_req_t store_head,
    input  wire         store_head_valid,
    output logic        store_head_ack,

    // Memory side
    output mem_req_t    mem_req,
    output logic        mem_req_valid,
    input  wire         mem_ack
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Eligibility
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic   grant_store;
    logic   last_grant_store;
    logic   store_hold;
    logic   addr_conflict;
    logic   load_eligible;
    logic   store_eligible;
    logic   pick_store;
    logic   grant_now;

    // Load must not pass an older store to the same address
    assign addr_conflict = store_head_valid & (load_head.addr == store_head.addr);

    // Store head is blank for a cycle after its ack, so the next store
    // has not been compared yet
    assign load_eligible  = load_head_valid & ~addr_conflict & ~store_hold;
    assign store_eligible = store_head_valid;

    // Round robin on a tie, otherwise whoever is eligible
    always_comb
    begin
        if (load_eligible & store_eligible)
        begin
            pick_store = ~last_grant_store;
        end
        else
        begin
            pick_store = store_eligible;
        end
    end

    assign grant_now = ~mem_req_valid & (load_eligible | store_eligible);

    // Head ack goes back to whichever queue owns the request
    assign load_head_ack  = mem_req_valid & mem_ack & ~grant_store;
    assign store_head_ack = mem_req_valid & mem_ack & grant_store;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grant state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            mem_req_valid    <= 1'b0;
            grant_store      <= 1'b0;
            last_grant_store <= 1'b1;
            store_hold       <= 1'b0;
        end
        else
        begin
            store_hold <= store_head_ack;
            if (grant_now)
            begin
                mem_req_valid <= 1'b1;
                grant_store   <= pick_store;
            end
            else if (mem_req_valid & mem_ack)
            begin
                mem_req_valid    <= 1'b0;
                last_grant_store <= grant_store;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Held unchanged until mem_ack
    always_ff @(posedge clk_in)
    begin
        if (grant_now)
        begin
            if (pick_store)
            begin
                mem_req.is_store <= 1'b1;
                mem_req.addr     <= store_head.addr;
                mem_req.data     <= store_head.data;
                mem_req.mask     <= store_head.mask;
            end
            else
            begin
                mem_req.is_store <= 1'b0;
                mem_req.addr     <= load_head.addr;
                mem_req.data     <= '0;
                mem_req.mask     <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mem_request_front.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_req_defs.svh"

module mem_request_front
    import mem_req_pkg::*;
(
    input  wire                                 clk_in,
    input  wire                                 reset_in,

    // Load stream
    input  wire                                 load_req_valid,
    input  wire [`MEM_ADDR_WIDTH - 1 : 0]       load_req_addr,
    output logic                                load_req_ack,
    output logic                                load_queue_full,
    output logic                                load_queue_empty,

    // Store stream
    input  wire                                 store_req_valid,
    input  wire [`MEM_ADDR_WIDTH - 1 : 0]       store_req_addr,
    input  wire [`MEM_DATA_WIDTH - 1 : 0]       store_req_data,
    input  wire [(`MEM_DATA_WIDTH / 8) - 1 : 0] store_req_mask,
    output logic                                store_req_ack,
    output logic                                store_queue_full,
    output logic                                store_queue_empty,

    // Memory request port
    output logic                                mem_req_valid,
    output logic                                mem_req_is_store,
    output logic [`MEM_ADDR_WIDTH - 1 : 0]      mem_req_addr,
    output logic [`MEM_DATA_WIDTH - 1 : 0]      mem_req_data,
    output logic [(`MEM_DATA_WIDTH / 8) - 1 : 0] mem_req_mask,
    input  wire                                 mem_ack
);

    load_req_t  load_req;
    store_req_t store_req;

    load_req_t  load_head;
    logic       load_head_valid;
    logic       load_head_ack;

    store_req_t store_head;
    logic       store_head_valid;
    logic       store_head_ack;

    mem_req_t   mem_req;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Payload packing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign load_req.addr   = load_req_addr;

    assign store_req.addr  = store_req_addr;
    assign store_req.data  = store_req_data;
    assign store_req.mask  = store_req_mask;

    assign mem_req_is_store = mem_req.is_store;
    assign mem_req_addr     = mem_req.addr;
    assign mem_req_data     = mem_req.data;
    assign mem_req_mask     = mem_req.mask;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request queues and arbiter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fifo_queue #(
        .QUEUE_SIZE         (`LOAD_QUEUE_SIZE),
        .payload_t          (load_req_t)
    ) load_queue (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .is_empty           (load_queue_empty),
        .is_full            (load_queue_full),
        .request_in         (load_req),
        .request_valid_in   (load_req_valid),
        .issue_ack_out      (load_req_ack),
        .request_out        (load_head),
        .request_valid_out  (load_head_valid),
        .issue_ack_in       (load_head_ack)
    );

    fifo_queue #(
        .QUEUE_SIZE         (`STORE_QUEUE_SIZE),
        .payload_t          (store_req_t)
    ) store_queue (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .is_empty           (store_queue_empty),
        .is_full            (store_queue_full),
        .request_in         (store_req),
        .request_valid_in   (store_req_valid),
        .issue_ack_out      (store_req_ack),
        .request_out        (store_head),
        .request_valid_out  (store_head_valid),
        .issue_ack_in       (store_head_ack)
    );

    mem_request_arbiter arbiter (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .load_head          (load_head),
        .load_head_valid    (load_head_valid),
        .load_head_ack      (load_head_ack),
        .store_head         (store_head),
        .store_head_valid   (store_head_valid),
        .store_head_ack     (store_head_ack),
        .mem_req            (mem_req),
        .mem_req_valid      (mem_req_valid),
        .mem_ack            (mem_ack)
    );

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/mem_req_pkg.sv
design/fifo_queue.sv
design/mem_request_arbiter.sv
design/mem_request_front.sv
tb/tb_mem_request_front.sv

//--- tb/tb_mem_request_front.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_req_defs.svh"

module tb_mem_request_front;

    localparam int ADDR_W = `MEM_ADDR_WIDTH;
    localparam int MASK_W = `MEM_DATA_WIDTH / 8;
    localparam int REQ_W  = ADDR_W + `MEM_DATA_WIDTH + MASK_W;
    localparam logic [31 : 0] SEED = 32'd90;
    // Six tests add up to roughly a thousand cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic                               clk_in;
    logic                               reset_in;
    logic                               load_req_valid;
    logic [ADDR_W - 1 : 0]              load_req_addr;
    logic                               load_req_ack;
    logic                               load_queue_full;
    logic                               load_queue_empty;
    logic                               store_req_valid;
    logic [ADDR_W - 1 : 0]              store_req_addr;
    logic [`MEM_DATA_WIDTH - 1 : 0]     store_req_data;
    logic [MASK_W - 1 : 0]              store_req_mask;
    logic                               store_req_ack;
    logic                               store_queue_full;
    logic                               store_queue_empty;
    logic                               mem_req_valid;
    logic                               mem_req_is_store;
    logic [ADDR_W - 1 : 0]              mem_req_addr;
    logic [`MEM_DATA_WIDTH - 1 : 0]     mem_req_data;
    logic [MASK_W - 1 : 0]              mem_req_mask;
    logic                               mem_ack = 1'b0;
    logic [REQ_W - 1 : 0]               mem_req_word;

    // Scoreboard words are {addr, data, mask} with zero data and mask for loads
    logic [REQ_W - 1 : 0]   load_sb [$];
    logic [REQ_W - 1 : 0]   store_sb [$];

    int             load_accepted = 0;
    int             store_accepted = 0;
    int             load_issued = 0;
    int             store_issued = 0;
    int             mon_errors = 0;
    int             prop_errors = 0;
    int             main_errors = 0;
    int             cycle_count = 0;
    int             tests_run = 0;
    int             errors_before = 0;
    logic [31 : 0]  ack_percent = '0;
    logic           rr_check = 1'b0;
    logic           prev_valid = 1'b0;
    logic           prev_store = 1'b0;
    logic           prev_load_busy = 1'b0;
    logic           prev_store_busy = 1'b0;
    // Each process has its own generator derived from the seed
    logic [31 : 0]  load_rng = SEED;
    logic [31 : 0]  store_rng = SEED ^ 32'h0000_5a00;
    logic [31 : 0]  ack_rng = SEED ^ 32'h005a_0000;

    assign mem_req_word = {mem_req_addr, mem_req_data, mem_req_mask};

    mem_request_front dut (.*);

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    always @(posedge clk_in)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31 : 0] xorshift32(input logic [31 : 0] x);
        logic [31 : 0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bit value_ok(input string name, input logic [REQ_W - 1 : 0] got,
                                    input logic [REQ_W - 1 : 0] exp);
        bit ok;
        ok = (got === exp);
        assert (ok)
        else $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        return ok;
    endfunction

    function automatic int total_errors();
        return mon_errors + prop_errors + main_errors;
    endfunction

    task automatic expect_value(input string name, input logic [REQ_W - 1 : 0] got,
                                input logic [REQ_W - 1 : 0] exp);
        if (!value_ok(name, got, exp))
        begin
            main_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = total_errors() - errors_before;
        tests_run++;
        errors_before = total_errors();
        $display("Test %0d %s: %0d errors", tests_run, name, errs);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk_in);
            #1;
        end
    endtask

    // Hold the request until its ack is seen
    task automatic send_load(input logic [ADDR_W - 1 : 0] addr);
        load_req_addr  = addr;
        load_req_valid = 1'b1;
        do @(posedge clk_in); while (!load_req_ack);
        #1;
        load_req_valid = 1'b0;
    endtask

    task automatic send_store(input logic [ADDR_W - 1 : 0] addr,
                              input logic [`MEM_DATA_WIDTH - 1 : 0] data,
                              input logic [MASK_W - 1 : 0] mask);
        store_req_addr  = addr;
        store_req_data  = data;
        store_req_mask  = mask;
        store_req_valid = 1'b1;
        do @(posedge clk_in); while (!store_req_ack);
        #1;
        store_req_valid = 1'b0;
    endtask

    // Random loads take even addresses and stores odd ones, so they never conflict
    task automatic send_random_load();
        load_rng = xorshift32(load_rng);
        send_load({load_rng[ADDR_W - 1 : 1], 1'b0});
    endtask

    task automatic send_random_store();
        store_rng = xorshift32(store_rng);
        send_store({store_rng[ADDR_W - 1 : 1], 1'b1}, xorshift32(store_rng),
                   store_rng[MASK_W - 1 : 0]);
    endtask

    task automatic wait_drained();
        while (load_sb.size() != 0 || store_sb.size() != 0 || mem_req_valid)
        begin
            @(posedge clk_in);
            #1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory responder and monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Ack rate in force over the cycle that just ended
    always @(posedge clk_in)
    begin : responder
        logic [31 : 0] percent;
        percent = ack_percent;
        #1;
        ack_rng = xorshift32(ack_rng);
        mem_ack = mem_req_valid && ((ack_rng % 32'd100) < percent);
    end

    task automatic check_issue();
        bit both_pending;
        both_pending = (load_sb.size() != 0) && (store_sb.size() != 0);
        if (mem_req_is_store)
        begin
            store_issued++;
        end
        else
        begin
            load_issued++;
        end
        if (mem_req_is_store ? (store_sb.size() == 0) : (load_sb.size() == 0))
        begin
            mon_errors++;
            $display("Request issued at %0t ns with nothing of its kind pending", $time);
        end
        else if (mem_req_is_store)
        begin
            if (!value_ok("mem_req store fields", mem_req_word, store_sb.pop_front()))
            begin
                mon_errors++;
            end
        end
        else
        begin
            assert (store_sb.size() == 0 || store_sb[0][REQ_W - 1 -: ADDR_W] != mem_req_addr)
            else
            begin
                mon_errors++;
                $display("Load to %0h issued ahead of the older store to it", mem_req_addr);
            end
            if (!value_ok("mem_req load fields", mem_req_word, load_sb.pop_front()))
            begin
                mon_errors++;
            end
        end
        assert (!(rr_check && prev_valid && both_pending && prev_store == mem_req_is_store))
        else
        begin
            mon_errors++;
            $display("Same request kind issued twice in a row at %0t ns", $time);
        end
        prev_valid = rr_check;
        prev_store = mem_req_is_store;
    endtask

    always @(posedge clk_in)
    begin
        if (!reset_in)
        begin
            if (load_req_ack)
            begin
                load_sb.push_back({load_req_addr, {(REQ_W - ADDR_W){1'b0}}});
                load_accepted++;
            end
            if (store_req_ack)
            begin
                store_sb.push_back({store_req_addr, store_req_data, store_req_mask});
                store_accepted++;
            end
            // The accept edge was the previous one, which needed a free slot
            assert (!(load_req_ack && prev_load_busy) && !(store_req_ack && prev_store_busy))
            else
            begin
                mon_errors++;
                $display("Upstream ack at %0t ns although the queue was full", $time);
            end
            if (mem_req_valid && mem_ack)
            begin
                check_issue();
            end
            prev_load_busy  = load_queue_full && !(mem_req_valid && mem_ack && !mem_req_is_store);
            prev_store_busy = store_queue_full && !(mem_req_valid && mem_ack && mem_req_is_store);
        end
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        (mem_req_valid && !mem_ack) |=> (mem_req_valid && $stable(mem_req_word)
                                         && $stable(mem_req_is_store)))
    else
    begin
        prop_errors++;
        $display("mem_req changed or dropped at %0t ns before mem_ack", $time);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        int     accepted_before;
        logic   got_ack;

        reset_in        = 1'b1;
        load_req_valid  = 1'b0;
        load_req_addr   = '0;
        store_req_valid = 1'b0;
        store_req_addr  = '0;
        store_req_data  = '0;
        store_req_mask  = '0;
        repeat (3) @(posedge clk_in);
        #1;
        reset_in = 1'b0;

        expect_value("mem_req_valid", REQ_W'(mem_req_valid), REQ_W'(0));
        expect_value("load_req_ack", REQ_W'(load_req_ack), REQ_W'(0));
        expect_value("store_req_ack", REQ_W'(store_req_ack), REQ_W'(0));
        expect_value("load_queue_empty", REQ_W'(load_queue_empty), REQ_W'(1));
        expect_value("store_queue_empty", REQ_W'(store_queue_empty), REQ_W'(1));
        expect_value("load_queue_full", REQ_W'(load_queue_full), REQ_W'(0));
        expect_value("store_queue_full", REQ_W'(store_queue_full), REQ_W'(0));
        finish_test("reset state");

        ack_percent = 32'd70;
        repeat (6) send_random_load();
        repeat (3) send_random_store();
        wait_drained();
        finish_test("order and payload");

        // Offer loads for a while with memory stalled
        ack_percent     = 32'd0;
        accepted_before = load_accepted;
        load_rng        = xorshift32(load_rng);
        load_req_addr   = {load_rng[ADDR_W - 1 : 1], 1'b0};
        load_req_valid  = 1'b1;
        repeat (40)
        begin
            @(posedge clk_in);
            got_ack = load_req_ack;
            #1;
            if (got_ack)
            begin
                load_rng      = xorshift32(load_rng);
                load_req_addr = {load_rng[ADDR_W - 1 : 1], 1'b0};
            end
        end
        load_req_valid = 1'b0;
        idle_cycles(2);
        assert (load_accepted - accepted_before <= `LOAD_QUEUE_SIZE + 1)
        else
        begin
            main_errors++;
            $display("Load queue took %0d requests while stalled",
                     load_accepted - accepted_before);
        end
        expect_value("load_queue_full", REQ_W'(load_queue_full), REQ_W'(1));
        ack_percent = 32'd100;
        wait_drained();
        finish_test("back-pressure");

        ack_percent = 32'd0;
        rr_check    = 1'b1;
        repeat (`LOAD_QUEUE_SIZE) send_random_load();
        repeat (`STORE_QUEUE_SIZE) send_random_store();
        ack_percent = 32'd100;
        wait_drained();
        rr_check = 1'b0;
        finish_test("round-robin");

        // Store to A behind another store and load to A behind another load
        ack_percent = 32'd0;
        send_load(32'h0000_1000);
        send_store(32'h0000_2001, 32'h1234_5678, 4'hf);
        send_store(32'h0000_3000, 32'h0bad_cafe, 4'h3);
        send_load(32'h0000_3000);
        ack_percent = 32'd100;
        wait_drained();
        finish_test("load-after-store hold");

        ack_percent = 32'd50;
        fork
            repeat (40)
            begin
                idle_cycles(int'(load_rng % 32'd4));
                send_random_load();
            end
            repeat (24)
            begin
                idle_cycles(int'(store_rng % 32'd4));
                send_random_store();
            end
        join
        wait_drained();
        expect_value("load issued count", REQ_W'(load_issued), REQ_W'(load_accepted));
        expect_value("store issued count", REQ_W'(store_issued), REQ_W'(store_accepted));
        expect_value("load_queue_empty", REQ_W'(load_queue_empty), REQ_W'(1));
        expect_value("store_queue_empty", REQ_W'(store_queue_empty), REQ_W'(1));
        finish_test("random traffic");

        $display("Tests %0d, errors %0d, loads issued %0d, stores issued %0d",
                 tests_run, total_errors(), load_issued, store_issued);
        if (total_errors() == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
